// ==== ahb_pkg.sv ====
package ahb_pkg;

    // transfer type as driven by the master
    typedef enum logic [1:0] {
        IDLE   = 2'b00,
        BUSY   = 2'b01,
        NONSEQ = 2'b10,
        SEQ    = 2'b11
    } htrans_t;

    typedef logic [2:0] hsize_t;

    // only 32 bit transfers are served
    localparam hsize_t hsize_word = 3'b010;

    typedef logic hresp_t;

    localparam hresp_t hresp_okay  = 1'b0;
    localparam hresp_t hresp_error = 1'b1;

    typedef logic [31:0] haddr_t;  // byte address
    typedef logic [31:0] hdata_t;

endpackage

// ==== mem_pkg.sv ====
package mem_pkg;

    localparam int mem_words = 64;

    // byte window, both ends inclusive
    localparam ahb_pkg::haddr_t mem_base = 32'h0000_0a00;
    localparam ahb_pkg::haddr_t mem_end  = 32'h0000_0aff;

    // word index relative to mem_base
    typedef logic [$clog2(mem_words)-1:0] word_idx_t;

    typedef logic [1:0] wait_cnt_t;

    // hready low cycles per data phase
    // read_wait needs to stay at least 1 since the array read is registered
    localparam wait_cnt_t read_wait  = 2'd2;
    localparam wait_cnt_t write_wait = 2'd1;

endpackage

// ==== ahb_addr_phase.sv ====
`timescale 1ns/10ps

module ahb_addr_phase (
    input  logic               mem_intf,
    input  logic               rst,
    input  logic               hsel,
    input  ahb_pkg::haddr_t    haddr,
    input  ahb_pkg::htrans_t   htrans,
    input  logic               hwrite,
    input  ahb_pkg::hsize_t    hsize,
    input  logic               hready,
    output logic               xfer_valid,
    output logic               xfer_write,
    output logic               xfer_err,
    output mem_pkg::word_idx_t xfer_idx
);
    import ahb_pkg::*;
    import mem_pkg::*;

    logic   accept;
    logic   in_range;
    logic   size_ok;
    haddr_t offset;

    // IDLE and BUSY never start a data phase
    assign accept   = hready && hsel && (htrans == NONSEQ || htrans == SEQ);
    assign in_range = (haddr >= mem_base) && (haddr <= mem_end);
    assign size_ok  = (hsize == hsize_word);
    assign offset   = haddr - mem_base;

    always_ff @(posedge mem_intf) begin
        if (rst) begin
            xfer_valid <= 1'b0;
            xfer_write <= 1'b0;
            xfer_err   <= 1'b0;
        end else if (hready) begin  // address held by master while hready low
            xfer_valid <= accept;
            if (accept) begin
                xfer_write <= hwrite;
                xfer_err   <= !in_range || !size_ok;
            end
        end
    end

    always_ff @(posedge mem_intf) begin
        if (accept)
            xfer_idx <= word_idx_t'(offset >> 2);
    end

    // the array address must stay put for the whole data phase
    assert property (@(posedge mem_intf) disable iff (rst)
        !hready |=> $stable(xfer_idx));

endmodule

// ==== mem_ctrl.sv ====
`timescale 1ns/10ps

module mem_ctrl (
    input  logic            mem_intf,
    input  logic            rst,
    input  logic            xfer_valid,
    input  logic            xfer_write,
    input  logic            xfer_err,
    output logic            hready,
    output ahb_pkg::hresp_t hresp,
    output logic            rd_en,
    output logic            wr_en,
    output logic            rd_done
);
    import ahb_pkg::*;
    import mem_pkg::*;

    typedef enum logic [1:0] {
        st_idle,
        st_wait,
        st_complete,
        st_err_first
    } state_t;

    state_t    state;
    state_t    cur_state;
    state_t    next_state;
    wait_cnt_t cnt;
    wait_cnt_t cur_cnt;
    wait_cnt_t wait_len;
    logic      last_wait;

    assign wait_len = xfer_write ? write_wait : read_wait;

    // st_idle in the register means the previous data phase has ended,
    // so the freshly captured transfer decides the state of this cycle
    always_comb begin
        cur_state = state;
        cur_cnt   = cnt;
        if (state == st_idle) begin
            cur_cnt = wait_len - 2'd1;  // wait cycles left after this one
            if (xfer_valid) begin
                if (xfer_err)
                    cur_state = st_err_first;
                else if (wait_len != '0)
                    cur_state = st_wait;
                else
                    cur_state = st_complete;
            end
        end
    end

    assign last_wait = (cur_cnt == '0);

    always_comb begin
        case (cur_state)
            st_wait:      next_state = last_wait ? st_complete : st_wait;
            st_err_first: next_state = st_complete;  // second error cycle
            default:      next_state = st_idle;
        endcase
    end

    always_ff @(posedge mem_intf) begin
        if (rst) begin
            state <= st_idle;
            cnt   <= '0;
        end else begin
            state <= next_state;
            cnt   <= cur_cnt - 2'd1;
        end
    end

    assign hready = (cur_state == st_idle) || (cur_state == st_complete);

    always_comb begin
        hresp = hresp_okay;
        if (cur_state == st_err_first || (cur_state == st_complete && xfer_err))
            hresp = hresp_error;
    end

    // read is launched one cycle early so data lands in the completing cycle
    assign rd_en   = (cur_state == st_wait) && last_wait && !xfer_write;
    assign wr_en   = (cur_state == st_complete) && xfer_write && !xfer_err;
    assign rd_done = (cur_state == st_complete) && !xfer_write && !xfer_err;

    // two cycle ERROR response, second cycle releases hready
    assert property (@(posedge mem_intf) disable iff (rst)
        (cur_state == st_err_first) |=> (hresp == hresp_error && hready));

    assert property (@(posedge mem_intf) disable iff (rst)
        !(rd_en && wr_en));

endmodule

// ==== mem_array.sv ====
`timescale 1ns/10ps

module mem_array (
    input  logic               mem_intf,
    input  logic               rst,
    input  logic               rd_en,
    input  logic               wr_en,
    input  mem_pkg::word_idx_t idx,
    input  ahb_pkg::hdata_t    wr_data,
    output ahb_pkg::hdata_t    rd_data
);
    import ahb_pkg::*;
    import mem_pkg::*;

    hdata_t mem [mem_words];

    // each word starts out holding its own index
    always_ff @(posedge mem_intf) begin
        if (rst) begin
            for (int i = 0; i < mem_words; i++)
                mem[i] <= hdata_t'(i);
        end else if (wr_en) begin
            mem[idx] <= wr_data;  // hwdata of the completing write cycle
        end
    end

    // registered read, valid the cycle after rd_en
    always_ff @(posedge mem_intf) begin
        if (rd_en)
            rd_data <= mem[idx];
    end

endmodule

// ==== rdata_path.sv ====
`timescale 1ns/10ps

module rdata_path (
    input  logic            mem_intf,
    input  logic            rst,
    input  logic            rd_done,
    input  ahb_pkg::hdata_t rd_data,
    output ahb_pkg::hdata_t hrdata
);
    import ahb_pkg::*;

    logic done_q;

    always_ff @(posedge mem_intf) begin
        if (rst)
            done_q <= 1'b0;
        else
            done_q <= rd_done;
    end

    // bus stays at zero outside the completing read cycle
    always_comb begin
        hrdata = '0;
        if (rd_done)
            hrdata = rd_data;
    end

    // read completion is a single cycle pulse, so hrdata drops back to zero
    assert property (@(posedge mem_intf) disable iff (rst)
        done_q |-> !rd_done);

endmodule

// ==== ahb_mem_top.sv ====
`timescale 1ns/10ps

module ahb_mem_top (
    input  logic             mem_intf,
    input  logic             rst,
    input  logic             hsel,
    input  ahb_pkg::haddr_t  haddr,
    input  ahb_pkg::htrans_t htrans,
    input  logic             hwrite,
    input  ahb_pkg::hsize_t  hsize,
    input  ahb_pkg::hdata_t  hwdata,
    output ahb_pkg::hdata_t  hrdata,
    output logic             hready,
    output ahb_pkg::hresp_t  hresp
);
    import ahb_pkg::*;
    import mem_pkg::*;

    logic      xfer_valid;
    logic      xfer_write;
    logic      xfer_err;
    word_idx_t xfer_idx;
    logic      rd_en;
    logic      wr_en;
    logic      rd_done;
    hdata_t    rd_data;

    // single slave, own hready doubles as hreadyin
    ahb_addr_phase u_addr_phase (
        .mem_intf   (mem_intf),
        .rst        (rst),
        .hsel       (hsel),
        .haddr      (haddr),
        .htrans     (htrans),
        .hwrite     (hwrite),
        .hsize      (hsize),
        .hready     (hready),
        .xfer_valid (xfer_valid),
        .xfer_write (xfer_write),
        .xfer_err   (xfer_err),
        .xfer_idx   (xfer_idx)
    );

    mem_ctrl u_ctrl (
        .mem_intf   (mem_intf),
        .rst        (rst),
        .xfer_valid (xfer_valid),
        .xfer_write (xfer_write),
        .xfer_err   (xfer_err),
        .hready     (hready),
        .hresp      (hresp),
        .rd_en      (rd_en),
        .wr_en      (wr_en),
        .rd_done    (rd_done)
    );

    mem_array u_array (
        .mem_intf (mem_intf),
        .rst      (rst),
        .rd_en    (rd_en),
        .wr_en    (wr_en),
        .idx      (xfer_idx),
        .wr_data  (hwdata),
        .rd_data  (rd_data)
    );

    rdata_path u_rdata (
        .mem_intf (mem_intf),
        .rst      (rst),
        .rd_done  (rd_done),
        .rd_data  (rd_data),
        .hrdata   (hrdata)
    );

endmodule

// ==== tb_ahb_mem.sv ====
`timescale 1ns/10ps

module tb_ahb_mem;
    import ahb_pkg::*;
    import mem_pkg::*;

    localparam int clk_period   = 100;
    localparam int reset_cycles = 8;
    localparam int n_entries    = 24;

    typedef struct packed {
        htrans_t htrans;
        logic    write;
        haddr_t  addr;
        hsize_t  size;
        hdata_t  data;  // write data, unused for reads
        hresp_t  resp;
    } xfer_entry_t;

    logic    mem_intf;
    logic    rst;
    logic    hsel;
    haddr_t  haddr;
    htrans_t htrans;
    logic    hwrite;
    hsize_t  hsize;
    hdata_t  hwdata;
    hdata_t  hrdata;
    logic    hready;
    hresp_t  hresp;

    xfer_entry_t tab [n_entries];
    hdata_t      shadow [mem_words];
    logic [31:0] rng_state;
    int          n_fill;
    int          errors;
    int          n_pass;

    ahb_mem_top DUT (
        .mem_intf (mem_intf),
        .rst      (rst),
        .hsel     (hsel),
        .haddr    (haddr),
        .htrans   (htrans),
        .hwrite   (hwrite),
        .hsize    (hsize),
        .hwdata   (hwdata),
        .hrdata   (hrdata),
        .hready   (hready),
        .hresp    (hresp)
    );

    initial begin
        mem_intf = 1'b0;
        forever #(clk_period / 2) mem_intf = ~mem_intf;
    end

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    task automatic add_xfer(input htrans_t t, input logic w, input haddr_t a,
                            input hsize_t s, input hresp_t r);
        xfer_entry_t e;
        e.htrans = t;
        e.write  = w;
        e.addr   = a;
        e.size   = s;
        e.resp   = r;
        e.data   = '0;
        if (w) begin
            rng_state = xorshift32(rng_state);
            e.data    = rng_state;
        end
        tab[n_fill] = e;
        n_fill++;
    endtask

    task automatic build_table();
        n_fill = 0;
        // init pattern reads
        add_xfer(NONSEQ, 1'b0, 32'h0000_0a00, hsize_word, hresp_okay);
        add_xfer(NONSEQ, 1'b0, 32'h0000_0a04, hsize_word, hresp_okay);
        add_xfer(NONSEQ, 1'b0, 32'h0000_0afc, hsize_word, hresp_okay);
        add_xfer(NONSEQ, 1'b0, 32'h0000_0a40, hsize_word, hresp_okay);
        // write then read back with neighbours
        add_xfer(NONSEQ, 1'b1, 32'h0000_0a20, hsize_word, hresp_okay);
        add_xfer(NONSEQ, 1'b0, 32'h0000_0a20, hsize_word, hresp_okay);
        add_xfer(NONSEQ, 1'b0, 32'h0000_0a1c, hsize_word, hresp_okay);
        add_xfer(NONSEQ, 1'b0, 32'h0000_0a24, hsize_word, hresp_okay);
        // 0xb00 aliases onto word 0 if the range check is broken
        add_xfer(NONSEQ, 1'b1, 32'h0000_0b00, hsize_word, hresp_error);
        add_xfer(NONSEQ, 1'b0, 32'h0000_0a00, hsize_word, hresp_okay);
        add_xfer(NONSEQ, 1'b1, 32'h0000_09fc, hsize_word, hresp_error);  // lands on word 63
        add_xfer(NONSEQ, 1'b0, 32'h0000_0afc, hsize_word, hresp_okay);
        add_xfer(NONSEQ, 1'b1, 32'h0000_0a30, 3'b001, hresp_error);      // halfword
        add_xfer(NONSEQ, 1'b0, 32'h0000_0a30, hsize_word, hresp_okay);
        add_xfer(NONSEQ, 1'b0, 32'h0000_0b04, hsize_word, hresp_error);
        // burst traffic
        add_xfer(IDLE, 1'b0, 32'h0000_0000, hsize_word, hresp_okay);
        add_xfer(NONSEQ, 1'b1, 32'h0000_0a80, hsize_word, hresp_okay);
        add_xfer(SEQ, 1'b1, 32'h0000_0a84, hsize_word, hresp_okay);
        add_xfer(SEQ, 1'b1, 32'h0000_0a88, hsize_word, hresp_okay);
        add_xfer(IDLE, 1'b0, 32'h0000_0000, hsize_word, hresp_okay);
        add_xfer(NONSEQ, 1'b0, 32'h0000_0a80, hsize_word, hresp_okay);
        add_xfer(SEQ, 1'b0, 32'h0000_0a84, hsize_word, hresp_okay);
        add_xfer(BUSY, 1'b0, 32'h0000_0a88, hsize_word, hresp_okay);
        add_xfer(SEQ, 1'b0, 32'h0000_0a88, hsize_word, hresp_okay);
    endtask

    task automatic check_data(input hdata_t actual, input hdata_t expected, input string what);
        if (actual !== expected) begin
            $display("MISMATCH at %0t: %s, hrdata %h expected %h", $time, what, actual, expected);
            errors++;
        end
    endtask

    task automatic check_resp(input hresp_t actual, input hresp_t expected, input string what);
        if (actual !== expected) begin
            $display("MISMATCH at %0t: %s, hresp %b expected %b", $time, what, actual, expected);
            errors++;
        end
    endtask

    task automatic check_ready(input logic actual, input logic expected, input string what);
        if (actual !== expected) begin
            $display("MISMATCH at %0t: %s, hready %b expected %b", $time, what, actual, expected);
            errors++;
        end
    endtask

    task automatic drive_addr(input xfer_entry_t e);
        hsel   = 1'b1;
        htrans = e.htrans;
        haddr  = e.addr;
        hwrite = e.write;
        hsize  = e.size;
    endtask

    // called on the first falling edge after the accepting edge,
    // returns on the falling edge of the completing cycle
    task automatic run_data_phase(input int n);
        xfer_entry_t e;
        htrans_t     t;
        word_idx_t   widx;
        logic        active;
        logic        done;
        int          k;
        int          exp_waits;
        int          err_before;
        hdata_t      exp_data;
        hresp_t      exp_resp;
        string       what;
        string       dir;
        e          = tab[n];
        t          = e.htrans;
        err_before = errors;
        active     = (t == NONSEQ) || (t == SEQ);
        widx       = word_idx_t'((e.addr - mem_base) >> 2);
        exp_data   = '0;
        if (!active)
            exp_waits = 0;  // IDLE and BUSY
        else if (e.resp == hresp_error)
            exp_waits = 1;
        else if (e.write)
            exp_waits = int'(write_wait);
        else begin
            exp_waits = int'(read_wait);
            exp_data  = shadow[widx];
        end
        if (active && e.write)
            hwdata = e.data;
        k    = 0;
        done = 1'b0;
        while (!done) begin
            what = $sformatf("test %0d cycle %0d", n, k);
            check_ready(hready, k >= exp_waits, what);
            exp_resp = (e.resp == hresp_error) ? hresp_error : hresp_okay;
            check_resp(hresp, exp_resp, what);
            check_data(hrdata, (k >= exp_waits) ? exp_data : hdata_t'(0), what);
            if (hready === 1'b1) begin
                done = 1'b1;
            end else begin
                k++;
                @(negedge mem_intf);
            end
        end
        if (active && e.write && e.resp == hresp_okay)
            shadow[widx] = e.data;  // written on the closing edge
        if (e.write)
            dir = "write";
        else
            dir = "read";
        if (errors == err_before) begin
            n_pass++;
            $display("test %0d %s %s addr %h waits %0d: ok", n, t.name(), dir, e.addr, k);
        end else begin
            $display("test %0d %s %s addr %h waits %0d: mismatch", n, t.name(), dir, e.addr, k);
        end
    endtask

    initial begin : watchdog
        #((n_entries * (int'(read_wait) + 3) + reset_cycles) * clk_period);
        $display("timeout: transfers did not complete in time, hready may be stuck low");
        $display("Test failed");
        $finish;
    end

    initial begin
        rst       = 1'b1;
        hsel      = 1'b0;
        haddr     = '0;
        htrans    = IDLE;
        hwrite    = 1'b0;
        hsize     = hsize_word;
        hwdata    = '0;
        errors    = 0;
        n_pass    = 0;
        rng_state = 32'h44eb;
        for (int i = 0; i < mem_words; i++)
            shadow[i] = hdata_t'(i);
        build_table();

        repeat (reset_cycles) @(posedge mem_intf);
        @(negedge mem_intf);
        check_ready(hready, 1'b1, "after reset");
        check_resp(hresp, hresp_okay, "after reset");
        check_data(hrdata, '0, "after reset");
        rst = 1'b0;

        for (int i = 0; i < n_entries; i++) begin
            drive_addr(tab[i]);  // next address overlaps previous data phase
            @(negedge mem_intf);
            run_data_phase(i);
        end

        hsel   = 1'b0;
        htrans = IDLE;
        @(negedge mem_intf);
        check_ready(hready, 1'b1, "bus idle at end");
        check_resp(hresp, hresp_okay, "bus idle at end");
        check_data(hrdata, '0, "bus idle at end");

        $display("%0d of %0d tests ok, %0d mismatches", n_pass, n_entries, errors);
        if (errors == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

// ==== verilog.f ====
ahb_pkg.sv
mem_pkg.sv
ahb_addr_phase.sv
mem_ctrl.sv
mem_array.sv
rdata_path.sv
ahb_mem_top.sv
tb_ahb_mem.sv

// ==== run_sim.sh ====
#!/bin/sh
# build and run the AHB memory testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/10ps \
    --top-module tb_ahb_mem -f verilog.f -o tb_ahb_mem

# the simulator status is ignored here, the printed result decides
out=$(./obj_dir/tb_ahb_mem || true)
echo "$out"

if echo "$out" | grep -qx "Test completed successfully"; then
    exit 0
fi
exit 1
